// ==== src/rv_pkg.sv ====
package rv_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;     // Registers, addresses, instructions, data
  typedef logic [4:0]      reg_idx_t;
  typedef logic [3:0]      byte_en_t;  // One enable per byte lane
  typedef logic [6:0]      opcode_t;
  typedef logic [2:0]      funct3_t;
  typedef logic [3:0]      alu_op_t;

  // Major opcodes
  localparam opcode_t OP_LUI      = 7'b0110111;
  localparam opcode_t OP_AUIPC    = 7'b0010111;
  localparam opcode_t OP_JAL      = 7'b1101111;
  localparam opcode_t OP_JALR     = 7'b1100111;
  localparam opcode_t OP_BRANCH   = 7'b1100011;
  localparam opcode_t OP_LOAD     = 7'b0000011;
  localparam opcode_t OP_STORE    = 7'b0100011;
  localparam opcode_t OP_IMM      = 7'b0010011;
  localparam opcode_t OP_REG      = 7'b0110011;
  localparam opcode_t OP_MISC_MEM = 7'b0001111;
  localparam opcode_t OP_SYSTEM   = 7'b1110011;

  // Memory access size and sign
  localparam funct3_t F3_B  = 3'b000;
  localparam funct3_t F3_H  = 3'b001;
  localparam funct3_t F3_W  = 3'b010;
  localparam funct3_t F3_BU = 3'b100;
  localparam funct3_t F3_HU = 3'b101;

  // ALU operations
  localparam alu_op_t ALU_ADD    = 4'd0;
  localparam alu_op_t ALU_SUB    = 4'd1;
  localparam alu_op_t ALU_SLL    = 4'd2;
  localparam alu_op_t ALU_SLT    = 4'd3;
  localparam alu_op_t ALU_SLTU   = 4'd4;
  localparam alu_op_t ALU_XOR    = 4'd5;
  localparam alu_op_t ALU_SRL    = 4'd6;
  localparam alu_op_t ALU_SRA    = 4'd7;
  localparam alu_op_t ALU_OR     = 4'd8;
  localparam alu_op_t ALU_AND    = 4'd9;
  localparam alu_op_t ALU_PASS_B = 4'd10;  // Operand b straight through

endpackage

// ==== src/rv_ctrl_if.sv ====
interface rv_ctrl_if import rv_pkg::*; ();

  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  word_t    imm;           // Sign-extended, already in final position
  logic     use_imm;       // ALU operand b from imm
  alu_op_t  alu_op;
  logic     rf_we;
  logic     is_load;
  logic     is_store;
  funct3_t  mem_funct3;
  logic     is_branch;
  funct3_t  br_funct3;
  logic     is_jal;
  logic     is_jalr;
  logic     is_lui;
  logic     is_auipc;
  logic     halt_req;
  logic     illegal;

  modport decoder (
    output rs1, rs2, rd, imm, use_imm, alu_op, rf_we, is_load, is_store, mem_funct3,
           is_branch, br_funct3, is_jal, is_jalr, is_lui, is_auipc, halt_req, illegal
  );

  modport user (
    input rs1, rs2, rd, imm, use_imm, alu_op, rf_we, is_load, is_store, mem_funct3,
          is_branch, br_funct3, is_jal, is_jalr, is_lui, is_auipc, halt_req, illegal
  );

endinterface

// ==== src/rv_decode.sv ====
module rv_decode import rv_pkg::*; #(
  parameter int NUM_REGS = 32
) (
  input word_t           insn,
  rv_ctrl_if.decoder     ctrl
);

  localparam logic [6:0] F7_ALT = 7'b0100000;  // SUB and SRA/SRAI

  opcode_t    opcode;
  funct3_t    funct3;
  logic [6:0] funct7;
  reg_idx_t   rs1_f, rs2_f, rd_f;
  word_t      imm_i, imm_s, imm_b, imm_j, imm_u;
  logic       bad_enc;
  logic       uses_rs1, uses_rs2, uses_rd;
  logic       bad_reg;

  // Shared by OP and OP-IMM, alt selects SUB or SRA
  function automatic alu_op_t arith_op(funct3_t f3, logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign opcode = insn[6:0];
  assign rd_f   = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1_f  = insn[19:15];
  assign rs2_f  = insn[24:20];
  assign funct7 = insn[31:25];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  assign ctrl.rs1        = rs1_f;
  assign ctrl.rs2        = rs2_f;
  assign ctrl.rd         = rd_f;
  assign ctrl.mem_funct3 = funct3;
  assign ctrl.br_funct3  = funct3;

  always_comb begin
    ctrl.imm       = imm_i;
    ctrl.use_imm   = 1'b0;
    ctrl.alu_op    = ALU_ADD;
    ctrl.rf_we     = 1'b0;
    ctrl.is_load   = 1'b0;
    ctrl.is_store  = 1'b0;
    ctrl.is_branch = 1'b0;
    ctrl.is_jal    = 1'b0;
    ctrl.is_jalr   = 1'b0;
    ctrl.is_lui    = 1'b0;
    ctrl.is_auipc  = 1'b0;
    ctrl.halt_req  = 1'b0;
    bad_enc        = 1'b0;
    uses_rs1       = 1'b0;
    uses_rs2       = 1'b0;
    uses_rd        = 1'b0;

    case (opcode)
      OP_LUI: begin
        ctrl.imm     = imm_u;
        ctrl.use_imm = 1'b1;
        ctrl.alu_op  = ALU_PASS_B;
        ctrl.rf_we   = 1'b1;
        ctrl.is_lui  = 1'b1;
        uses_rd      = 1'b1;
      end
      OP_AUIPC: begin
        ctrl.imm      = imm_u;
        ctrl.rf_we    = 1'b1;
        ctrl.is_auipc = 1'b1;
        uses_rd       = 1'b1;
      end
      OP_JAL: begin
        ctrl.imm    = imm_j;
        ctrl.rf_we  = 1'b1;
        ctrl.is_jal = 1'b1;
        uses_rd     = 1'b1;
      end
      OP_JALR: begin
        ctrl.rf_we   = 1'b1;
        ctrl.is_jalr = 1'b1;
        uses_rd      = 1'b1;
        uses_rs1     = 1'b1;
        bad_enc      = (funct3 != 3'b000);
      end
      OP_BRANCH: begin
        ctrl.imm       = imm_b;
        ctrl.is_branch = 1'b1;
        uses_rs1       = 1'b1;
        uses_rs2       = 1'b1;
        bad_enc        = (funct3[2:1] == 2'b01);  // 010 and 011 unassigned
      end
      OP_LOAD: begin
        ctrl.use_imm = 1'b1;
        ctrl.rf_we   = 1'b1;
        ctrl.is_load = 1'b1;
        uses_rd      = 1'b1;
        uses_rs1     = 1'b1;
        bad_enc      = !(funct3 inside {F3_B, F3_H, F3_W, F3_BU, F3_HU});
      end
      OP_STORE: begin
        ctrl.imm      = imm_s;
        ctrl.use_imm  = 1'b1;
        ctrl.is_store = 1'b1;
        uses_rs1      = 1'b1;
        uses_rs2      = 1'b1;
        bad_enc       = !(funct3 inside {F3_B, F3_H, F3_W});
      end
      OP_IMM: begin
        ctrl.use_imm = 1'b1;
        ctrl.alu_op  = arith_op(funct3, (funct3 == 3'b101) && insn[30]);
        ctrl.rf_we   = 1'b1;
        uses_rd      = 1'b1;
        uses_rs1     = 1'b1;
        // Only the shifts carry a funct7
        if (funct3 == 3'b001) begin
          bad_enc = (funct7 != 7'd0);
        end else if (funct3 == 3'b101) begin
          bad_enc = (funct7 != 7'd0) && (funct7 != F7_ALT);
        end
      end
      OP_REG: begin
        ctrl.alu_op = arith_op(funct3, insn[30]);
        ctrl.rf_we  = 1'b1;
        uses_rd     = 1'b1;
        uses_rs1    = 1'b1;
        uses_rs2    = 1'b1;
        bad_enc     = !((funct7 == 7'd0) ||
                        (funct7 == F7_ALT && (funct3 == 3'b000 || funct3 == 3'b101)));
      end
      OP_MISC_MEM: bad_enc = (funct3 != 3'b000);  // FENCE, nothing to order here
      OP_SYSTEM: begin
        ctrl.halt_req = (insn[31:7] == '0);  // ECALL only
        bad_enc       = (insn[31:7] != '0);
      end
      default: bad_enc = 1'b1;
    endcase
  end

  // RV32E has fewer registers
  assign bad_reg = (uses_rs1 && rs1_f >= NUM_REGS) ||
                   (uses_rs2 && rs2_f >= NUM_REGS) ||
                   (uses_rd  && rd_f  >= NUM_REGS);

  assign ctrl.illegal = bad_enc || bad_reg;

endmodule

// ==== src/rv_regfile.sv ====
module rv_regfile import rv_pkg::*; #(
  parameter int NUM_REGS = 32
) (
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t rs1_idx,
  input  reg_idx_t rs2_idx,
  input  reg_idx_t rd_idx,
  input  word_t    rd_data,
  input  logic     we,
  output word_t    rs1_data,
  output word_t    rs2_data
);

  word_t regs [1:NUM_REGS-1];  // x0 has no storage

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd_idx != '0 && rd_idx < NUM_REGS) begin
      regs[rd_idx] <= rd_data;
    end
  end

  // x0 and out-of-range indices read as zero
  assign rs1_data = (rs1_idx == '0 || rs1_idx >= NUM_REGS) ? '0 : regs[rs1_idx];
  assign rs2_data = (rs2_idx == '0 || rs2_idx >= NUM_REGS) ? '0 : regs[rs2_idx];

endmodule

// ==== src/rv_alu.sv ====
module rv_alu import rv_pkg::*; (
  rv_ctrl_if.user ctrl,
  input  word_t   rs1_data,
  input  word_t   rs2_data,
  output word_t   result,
  output logic    br_taken
);

  word_t      op_a, op_b;
  logic [4:0] shamt;
  logic       br_cond;

  assign op_a  = rs1_data;
  assign op_b  = ctrl.use_imm ? ctrl.imm : rs2_data;
  assign shamt = op_b[4:0];  // Upper bits of the amount are ignored

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:    result = op_a + op_b;
      ALU_SUB:    result = op_a - op_b;
      ALU_SLL:    result = op_a << shamt;
      ALU_SLT:    result = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   result = {31'b0, op_a < op_b};
      ALU_XOR:    result = op_a ^ op_b;
      ALU_SRL:    result = op_a >> shamt;
      ALU_SRA:    result = $signed(op_a) >>> shamt;
      ALU_OR:     result = op_a | op_b;
      ALU_AND:    result = op_a & op_b;
      ALU_PASS_B: result = op_b;
      default:    result = '0;
    endcase
  end

  // Branches always compare the two registers
  always_comb begin
    case (ctrl.br_funct3)
      3'b000:  br_cond = (rs1_data == rs2_data);                   // BEQ
      3'b001:  br_cond = (rs1_data != rs2_data);                   // BNE
      3'b100:  br_cond = ($signed(rs1_data) <  $signed(rs2_data)); // BLT
      3'b101:  br_cond = ($signed(rs1_data) >= $signed(rs2_data)); // BGE
      3'b110:  br_cond = (rs1_data <  rs2_data);                   // BLTU
      3'b111:  br_cond = (rs1_data >= rs2_data);                   // BGEU
      default: br_cond = 1'b0;
    endcase
  end

  assign br_taken = ctrl.is_branch && br_cond;

endmodule

// ==== src/rv_lsu.sv ====
module rv_lsu import rv_pkg::*; (
  rv_ctrl_if.user ctrl,
  input  word_t    rs1_data,
  input  word_t    rs2_data,
  input  word_t    dmem_rdata,
  output word_t    dmem_addr,
  output word_t    dmem_wdata,
  output byte_en_t dmem_we,
  output word_t    load_data,
  output logic     misaligned
);

  word_t    ea;         // Effective byte address
  word_t    lane_data;  // Addressed lane moved down to bit 0
  byte_en_t lane_en;
  logic     bad_align;

  assign ea        = rs1_data + ctrl.imm;
  assign dmem_addr = {ea[31:2], 2'b00};

  always_comb begin
    case (ctrl.mem_funct3)
      F3_H, F3_HU: bad_align = ea[0];
      F3_W:        bad_align = (ea[1:0] != 2'b00);
      default:     bad_align = 1'b0;
    endcase
  end

  assign misaligned = (ctrl.is_load || ctrl.is_store) && bad_align;

  // Store data copied into every lane, enables pick the one that lands
  always_comb begin
    case (ctrl.mem_funct3)
      F3_B: begin
        dmem_wdata = {4{rs2_data[7:0]}};
        lane_en    = 4'b0001 << ea[1:0];
      end
      F3_H: begin
        dmem_wdata = {2{rs2_data[15:0]}};
        lane_en    = ea[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        dmem_wdata = rs2_data;
        lane_en    = 4'b1111;
      end
    endcase
  end

  assign dmem_we = (ctrl.is_store && !ctrl.illegal && !misaligned) ? lane_en : '0;

  assign lane_data = dmem_rdata >> {ea[1:0], 3'b000};

  always_comb begin
    case (ctrl.mem_funct3)
      F3_B:    load_data = {{24{lane_data[7]}}, lane_data[7:0]};
      F3_BU:   load_data = {24'b0, lane_data[7:0]};
      F3_H:    load_data = {{16{lane_data[15]}}, lane_data[15:0]};
      F3_HU:   load_data = {16'b0, lane_data[15:0]};
      default: load_data = dmem_rdata;
    endcase
  end

endmodule

// ==== src/rv_core.sv ====
module rv_core import rv_pkg::*; #(
  parameter word_t RESET_PC = '0,
  parameter int    NUM_REGS = 32
) (
  input  logic     clk,
  input  logic     rst,
  output word_t    imem_addr,
  input  word_t    imem_data,
  output word_t    dmem_addr,
  input  word_t    dmem_rdata,
  output word_t    dmem_wdata,
  output byte_en_t dmem_we,
  output logic     halt
);

  word_t    pc, pc_next;
  word_t    pc_plus4;
  word_t    pc_imm;       // Branch and JAL target, also the AUIPC result
  word_t    jalr_target;
  word_t    rs1_data, rs2_data;
  word_t    alu_result;
  word_t    load_data;
  word_t    wb_data;
  byte_en_t lsu_we;
  logic     br_taken;
  logic     misaligned;
  logic     rf_wr_en;

  rv_ctrl_if ctrl ();

  rv_decode #(.NUM_REGS(NUM_REGS)) decode_i (
    .insn (imem_data),
    .ctrl (ctrl.decoder)
  );

  rv_regfile #(.NUM_REGS(NUM_REGS)) regfile_i (
    .clk      (clk),
    .rst      (rst),
    .rs1_idx  (ctrl.rs1),
    .rs2_idx  (ctrl.rs2),
    .rd_idx   (ctrl.rd),
    .rd_data  (wb_data),
    .we       (rf_wr_en),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_alu alu_i (
    .ctrl     (ctrl.user),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .result   (alu_result),
    .br_taken (br_taken)
  );

  rv_lsu lsu_i (
    .ctrl       (ctrl.user),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .dmem_rdata (dmem_rdata),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (lsu_we),
    .load_data  (load_data),
    .misaligned (misaligned)
  );

  assign pc_plus4    = pc + 32'd4;
  assign pc_imm      = pc + ctrl.imm;
  assign jalr_target = (rs1_data + ctrl.imm) & ~32'd1;

  // Illegal instructions fall through to the next word
  always_comb begin
    pc_next = pc_plus4;
    if (!ctrl.illegal) begin
      if (ctrl.is_jalr) begin
        pc_next = jalr_target;
      end else if (ctrl.is_jal || br_taken) begin
        pc_next = pc_imm;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  always_comb begin
    if (ctrl.is_load) begin
      wb_data = load_data;
    end else if (ctrl.is_jal || ctrl.is_jalr) begin
      wb_data = pc_plus4;  // Link address
    end else if (ctrl.is_lui) begin
      wb_data = ctrl.imm;
    end else if (ctrl.is_auipc) begin
      wb_data = pc_imm;
    end else begin
      wb_data = alu_result;
    end
  end

  assign rf_wr_en = ctrl.rf_we && !ctrl.illegal && !misaligned;

  assign imem_addr = pc;
  // Memory must see no store and no halt while the core is held in reset
  assign dmem_we   = rst ? '0 : lsu_we;
  assign halt      = ctrl.halt_req && !rst;

endmodule

// ==== sim/rv_core_sva.sv ====
module rv_core_sva (
  input logic        clk,
  input logic        rst,
  input logic [31:0] imem_addr,
  input logic [31:0] dmem_addr,
  input logic [3:0]  dmem_we,
  input logic        halt
);

  // Fetch and data addresses are word aligned
  a_imem_align: assert property (@(posedge clk) disable iff (rst) imem_addr[1:0] == 2'b00)
    else $error("imem_addr not word aligned");

  a_dmem_align: assert property (@(posedge clk) disable iff (rst) dmem_addr[1:0] == 2'b00)
    else $error("dmem_addr not word aligned");

  // Quiet memory side while in reset
  a_reset_quiet: assert property (@(posedge clk) rst |-> (dmem_we == 4'b0000 && !halt))
    else $error("store or halt during reset");

  a_halt_no_store: assert property (@(posedge clk) halt |-> dmem_we == 4'b0000)
    else $error("store while halt is high");

endmodule

bind rv_core rv_core_sva sva_i (
  .clk       (clk),
  .rst       (rst),
  .imem_addr (imem_addr),
  .dmem_addr (dmem_addr),
  .dmem_we   (dmem_we),
  .halt      (halt)
);

// ==== sim/rv_core_tb.sv ====
module rv_core_tb;

  localparam int MEM_WORDS = 1024;  // 4 KiB unified memory

  logic        clk;
  logic        rst;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_rdata;
  logic [31:0] dmem_wdata;
  logic [3:0]  dmem_we;
  logic        halt;

  logic [31:0] mem [MEM_WORDS];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [3:0]  exp_en [$];
  logic [31:0] halt_pc;
  int          num_words;
  int          store_idx;
  int          error_count;
  int          cycles;
  int          limit;
  logic        done;

  rv_core dut_i (
    .clk        (clk),
    .rst        (rst),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_addr  (dmem_addr),
    .dmem_rdata (dmem_rdata),
    .dmem_wdata (dmem_wdata),
    .dmem_we    (dmem_we),
    .halt       (halt)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic check(string name, logic [31:0] actual, logic [31:0] expected);
    if (actual !== expected) begin
      $display("Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
      error_count++;
    end
  endtask

  // Program words go into memory and expectations into queues
  task automatic load_golden();
    int          fd;
    int          code;
    string       tag;
    string       rest;
    logic [31:0] a;
    logic [31:0] d;
    logic [3:0]  e;
    fd = $fopen("sim/rv_core_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open the golden file sim/rv_core_golden.txt");
      error_count++;
      return;
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", tag);
      if (code != 1) begin
        break;
      end
      if (tag == "#") begin
        code = $fgets(rest, fd);
      end else if (tag == "I") begin
        code = $fscanf(fd, "%h %h", a, d);
        if (code == 2) begin
          mem[a[11:2]] = d;
          num_words++;
        end else begin
          $display("Malformed program line in the golden file");
          error_count++;
        end
      end else if (tag == "S") begin
        code = $fscanf(fd, "%h %h %h", a, d, e);
        if (code == 3) begin
          exp_addr.push_back(a);
          exp_data.push_back(d);
          exp_en.push_back(e);
        end else begin
          $display("Malformed store line in the golden file");
          error_count++;
        end
      end else if (tag == "H") begin
        code = $fscanf(fd, "%h", halt_pc);
        if (code != 1) begin
          $display("Malformed halt line in the golden file");
          error_count++;
        end
      end else begin
        $display("Unknown tag %s in the golden file", tag);
        error_count++;
      end
    end
    $fclose(fd);
  endtask

  // Fetch first and read data once its address has settled
  always @(posedge clk) begin
    #1 imem_data = mem[imem_addr[11:2]];
    #1 dmem_rdata = mem[dmem_addr[11:2]];
  end

  // Outputs still show the instruction that completes at this edge
  always @(posedge clk) begin
    if (!rst && !done) begin
      if (dmem_we != 4'b0000) begin
        if (store_idx >= exp_addr.size()) begin
          $display("Unexpected store at %0t to address %h with data %h", $time,
                   dmem_addr, dmem_wdata);
          error_count++;
        end else begin
          check("dmem_addr", dmem_addr, exp_addr[store_idx]);
          check("dmem_wdata", dmem_wdata, exp_data[store_idx]);
          check("dmem_we", {28'b0, dmem_we}, {28'b0, exp_en[store_idx]});
        end
        store_idx++;
        for (int b = 0; b < 4; b++) begin
          if (dmem_we[b]) begin
            mem[dmem_addr[11:2]][8*b +: 8] = dmem_wdata[8*b +: 8];
          end
        end
      end
      if (halt) begin
        check("imem_addr", imem_addr, halt_pc);
        if (store_idx < exp_addr.size()) begin
          $display("Halt reached with %0d of %0d expected stores seen", store_idx,
                   exp_addr.size());
          error_count++;
        end
        done = 1'b1;
      end
    end
  end

  initial begin
    rst         = 1'b1;
    imem_data   = '0;
    dmem_rdata  = '0;
    done        = 1'b0;
    num_words   = 0;
    store_idx   = 0;
    error_count = 0;
    cycles      = 0;
    halt_pc     = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = {i[15:0], 16'h0} ^ (i * 4);  // Stray fetches see nonzero junk
    end
    load_golden();
    limit = 8 * num_words + 50;

    repeat (3) @(posedge clk);
    #1 rst = 1'b0;

    while (!done && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    #1;
    if (!done) begin
      $display("Timeout after %0d cycles without a halt", cycles);
      error_count++;
    end

    $display("Errors: %0d, stores seen: %0d of %0d", error_count, store_idx,
             exp_addr.size());
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== sim/rv_core_golden.txt ====
# I byte_address program_word | S address data byte_enables (program order)
# H halt_pc
I 000 40000513
I 004 FFB00093
I 008 00300113
I 00C 002081B3
I 010 00352023
I 014 40110233
I 018 00452223
I 01C 0020A2B3
I 020 0020B333
I 024 00552423
I 028 00652623
I 02C 0F00C393
I 030 3FF3F413
I 034 40046413
I 038 00752823
I 03C 00852A23
I 040 03300593
I 044 00B41633
I 048 40B0D6B3
I 04C 00B0D733
I 050 01441793
I 054 0117D813
I 058 00C52C23
I 05C 00D52E23
I 060 02E52023
I 064 02F52223
I 068 03052423
I 06C 07700893
I 070 00208463
I 074 03152623
I 078 00209463
I 07C 03152823
I 080 0020C463
I 084 03152823
I 088 0020D463
I 08C 03152823
I 090 0020E463
I 094 03152A23
I 098 0020F463
I 09C 03152A23
I 0A0 0080096F
I 0A4 03152C23
I 0A8 03252C23
I 0AC 0BC00993
I 0B0 00498A67
I 0B4 03152E23
I 0B8 03152E23
I 0BC 03152E23
I 0C0 03452E23
I 0C4 04050A93
I 0C8 80F0FB37
I 0CC 0A5B0B13
I 0D0 016A8023
I 0D4 016A80A3
I 0D8 016A8123
I 0DC 016A81A3
I 0E0 016A9223
I 0E4 016A9323
I 0E8 001A8B83
I 0EC 002ACC03
I 0F0 006A9C83
I 0F4 004ADD03
I 0F8 017AA423
I 0FC 018AA623
I 100 019AA823
I 104 01AAAA23
I 108 002AAB83
I 10C 016A90A3
I 110 017AAC23
I 114 ABCDEDB7
I 118 00012E17
I 11C 00708013
I 120 01BAAE23
I 124 03CAA023
I 128 020AA223
I 12C 0000000F
I 130 00000073
S 400 FFFFFFFE F
S 404 00000008 F
S 408 00000001 F
S 40C 00000000 F
S 410 FFFFFF0B F
S 414 0000070B F
S 418 38580000 F
S 41C FFFFFFFF F
S 420 00001FFF F
S 424 70B00000 F
S 428 00003858 F
S 42C 00000077 F
S 430 00000077 F
S 434 00000077 F
S 438 000000A4 F
S 43C 000000B4 F
S 440 A5A5A5A5 1
S 440 A5A5A5A5 2
S 440 A5A5A5A5 4
S 440 A5A5A5A5 8
S 444 F0A5F0A5 3
S 444 F0A5F0A5 C
S 448 FFFFFFA5 F
S 44C 000000A5 F
S 450 FFFFF0A5 F
S 454 0000F0A5 F
S 458 FFFFFFA5 F
S 45C ABCDE000 F
S 460 00012118 F
S 464 00000000 F
H 130

// ==== rv32i_core.f ====
src/rv_pkg.sv
src/rv_ctrl_if.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_lsu.sv
src/rv_core.sv
sim/rv_core_sva.sv
sim/rv_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv32i_core

sources:
  - src/rv_pkg.sv
  - src/rv_ctrl_if.sv
  - src/rv_decode.sv
  - src/rv_regfile.sv
  - src/rv_alu.sv
  - src/rv_lsu.sv
  - src/rv_core.sv
  - target: simulation
    files:
      - sim/rv_core_sva.sv
      - sim/rv_core_tb.sv
